/* bench/desStimulus.txt */
# Columns: op (E encrypt, D decrypt), key, input block, expected output block, in hex.
# Published DES known-answer vectors.
E 133457799BBCDFF1 0123456789ABCDEF 85E813540F0AB405
E 0E329232EA6D0D73 8787878787878787 0000000000000000
E 0123456789ABCDEF 4E6F772069732074 3FA40E8A984D4815
E 0000000000000000 0000000000000000 8CA64DE9C1B123A7
E FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF 7359B2163E4EDC58
E 3000000000000000 1000000000000001 958E6E627A05557B
E 1111111111111111 1111111111111111 F40379AB9E0EC533
E 0123456789ABCDEF 1111111111111111 17668DFC7292532D
E 1111111111111111 0123456789ABCDEF 8A5AE1F81AB8F2DD
E FEDCBA9876543210 0123456789ABCDEF ED39D950FA74BCC4
D 133457799BBCDFF1 85E813540F0AB405 0123456789ABCDEF
D 0E329232EA6D0D73 0000000000000000 8787878787878787
D 0123456789ABCDEF 3FA40E8A984D4815 4E6F772069732074
D 7CA110454A1A6E57 690F5B0D9A26939B 01A1D6D039776742

/* tb.f */
+incdir+common
common/desPkg.sv
keySchedule/keyPermChoice1.sv
keySchedule/roundKeyGen.sv
source/desRound.sv
source/desCore.sv
source/desAxiRegs.sv
source/desTop.sv
bench/desTb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the DES testbench with Verilator and runs it.
# Exit status is nonzero when the build, the run or any check fails.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f tb.f --top-module desTb -o desSim > "$LOG" 2>&1
if [ $? -ne 0 ]; then
   echo "Verilator build failed, see $LOG"
   exit 1
fi

./obj_dir/desSim >> "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -qx "Checks failed" "$LOG"; then
   echo "Simulation reported failures, see $LOG"
   exit 1
fi

echo "Simulation finished without failures"
exit 0

/* bench/desTb.sv */
`include "des_macros.svh"

module desTb;
   import desPkg::*;

   logic       clk;
   logic       rst;
   axiLiteReq  axiReq;
   axiLiteResp axiResp;

   // Vectors from the stimulus file.
   byte         opCodes[$];
   logic [63:0] keys[$];
   logic [63:0] blocks[$];
   logic [63:0] expectedOut[$];

   logic [63:0] lastKey;
   logic [63:0] lastData;
   logic [63:0] lastResult;

   int errors = 0;
   int checks = 0;
   int limit = 0;
   int cycleCount = 0;

   desTop desTop_i (
      .clk    (clk),
      .rst    (rst),
      .axiReq (axiReq),
      .axiResp(axiResp)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   task automatic check(input string name, input logic [63:0] expected,
                        input logic [63:0] actual);
      checks++;
      if (actual !== expected) begin
         $display("FAILED at time %0t: %s expected %h actual %h", $time, name, expected, actual);
         errors++;
      end
   endtask

   task automatic idleGap();
      repeat ($urandom_range(0, 1)) @(negedge clk);
   endtask

   // ********************
   // Bus tasks. Each returns just after a falling edge.
   task automatic axiWrite(input axiAddr addr, input axiData data, output logic [1:0] resp);
      int stall;
      stall = $urandom_range(0, 2);
      idleGap();
      axiReq.awaddr  = addr;
      axiReq.wdata   = data;
      axiReq.awvalid = 1'b1;
      axiReq.wvalid  = 1'b1;
      @(negedge clk);
      while (!axiResp.awready) @(negedge clk);
      check("wready", 64'(1'b1), 64'(axiResp.wready));  // Raised with awready.
      @(negedge clk);  // Handshake on the rising edge before.
      axiReq.awvalid = 1'b0;
      axiReq.wvalid  = 1'b0;
      while (!axiResp.bvalid) @(negedge clk);
      repeat (stall) @(negedge clk);
      resp = axiResp.bresp;
      axiReq.bready = 1'b1;
      @(negedge clk);
      axiReq.bready = 1'b0;
   endtask

   task automatic axiRead(input axiAddr addr, output axiData data, output logic [1:0] resp);
      int stall;
      stall = $urandom_range(0, 2);
      idleGap();
      axiReq.araddr  = addr;
      axiReq.arvalid = 1'b1;
      @(negedge clk);
      while (!axiResp.arready) @(negedge clk);
      @(negedge clk);
      axiReq.arvalid = 1'b0;
      while (!axiResp.rvalid) @(negedge clk);
      data = axiResp.rdata;
      resp = axiResp.rresp;
      repeat (stall) begin
         @(negedge clk);
         check("rvalid", 64'(1'b1), 64'(axiResp.rvalid));  // Held under back-pressure.
         check("rdata", 64'(data), 64'(axiResp.rdata));
      end
      axiReq.rready = 1'b1;
      @(negedge clk);
      axiReq.rready = 1'b0;
   endtask

   task automatic writeReg(input axiAddr addr, input axiData data);
      logic [1:0] resp;
      axiWrite(addr, data, resp);
      check($sformatf("bresp at 0x%02h", addr), 64'(`AXI_RESP_OKAY), 64'(resp));
   endtask

   task automatic readReg(input axiAddr addr, output axiData data);
      logic [1:0] resp;
      axiRead(addr, data, resp);
      check($sformatf("rresp at 0x%02h", addr), 64'(`AXI_RESP_OKAY), 64'(resp));
   endtask

   // ********************
   task automatic loadOperands(input logic [63:0] key, input logic [63:0] block);
      writeReg(`REG_KEY_HI, key[63:32]);
      writeReg(`REG_KEY_LO, key[31:0]);
      writeReg(`REG_DATA_HI, block[63:32]);
      writeReg(`REG_DATA_LO, block[31:0]);
      lastKey  = key;
      lastData = block;
   endtask

   task automatic waitForDone();
      axiData word;
      word = '0;
      while (!word[`STATUS_DONE]) readReg(`REG_STATUS, word);
      check("STATUS.busy", 64'(1'b0), 64'(word[`STATUS_BUSY]));
   endtask

   task automatic readResult(output logic [63:0] res);
      axiData hi;
      axiData lo;
      readReg(`REG_RESULT_HI, hi);
      readReg(`REG_RESULT_LO, lo);
      res = {hi, lo};
   endtask

   task automatic runCipher(input logic [63:0] key, input logic [63:0] block,
                            input logic decrypt, output logic [63:0] res);
      loadOperands(key, block);
      writeReg(`REG_CTRL, {30'b0, decrypt, 1'b1});
      waitForDone();
      readResult(res);
   endtask

   // A second start while the core runs must bounce.
   task automatic busyStartCheck(input logic [63:0] key, input logic [63:0] block,
                                 input logic [63:0] expected);
      logic [1:0]  resp;
      axiData      word;
      logic [63:0] res;
      loadOperands(key, block);
      writeReg(`REG_CTRL, 32'h1);
      readReg(`REG_STATUS, word);
      check("STATUS.busy", 64'(1'b1), 64'(word[`STATUS_BUSY]));
      axiWrite(`REG_CTRL, 32'h3, resp);
      check("bresp start while busy", 64'(`AXI_RESP_SLVERR), 64'(resp));
      readReg(`REG_CTRL, word);
      check("CTRL.decrypt", 64'(1'b0), 64'(word[`CTRL_DECRYPT]));
      waitForDone();
      readResult(res);
      lastResult = expected;
      check("RESULT after rejected start", expected, res);
   endtask

   task automatic readStimulus();
      int          fd;
      int          n;
      string       line;
      byte         op;
      logic [63:0] k;
      logic [63:0] d;
      logic [63:0] e;
      fd = $fopen("bench/desStimulus.txt", "r");
      if (fd == 0) begin
         $display("ERROR: cannot open the stimulus file bench/desStimulus.txt");
         errors++;
         return;
      end
      while ($fgets(line, fd) != 0) begin
         op = line.getc(0);
         if (op == "E" || op == "D") begin
            n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h", k, d, e);
            if (n == 3) begin
               opCodes.push_back(op);
               keys.push_back(k);
               blocks.push_back(d);
               expectedOut.push_back(e);
            end else begin
               $display("ERROR: a stimulus line could not be parsed: %s", line);
               errors++;
            end
         end
      end
      $fclose(fd);
   endtask

   // Cycle limit scales with the vector count.
   initial begin
      wait (limit != 0);
      while (cycleCount < limit) begin
         @(posedge clk);
         cycleCount++;
      end
      $display("ERROR: the run did not finish within %0d clock cycles", limit);
      errors++;
      $display("Summary: %0d errors in %0d checks", errors, checks);
      $display("Checks failed");
      $finish;
   end

   // ********************
   initial begin
      logic [1:0]  resp;
      axiData      word;
      logic [63:0] res;
      logic [63:0] back;
      int          seedValue;
      int          firstEnc;
      seedValue = $urandom(49870);
      axiReq    = '0;
      rst       = 1'b1;
      readStimulus();
      limit = opCodes.size() * 200 + 2000;
      repeat (3) @(negedge clk);
      rst = 1'b0;

      readReg(`REG_STATUS, word);
      check("STATUS after reset", 64'(0), 64'(word));
      readReg(`REG_RESULT_HI, word);
      check("RESULT_HI after reset", 64'(0), 64'(word));
      readReg(`REG_RESULT_LO, word);
      check("RESULT_LO after reset", 64'(0), 64'(word));

      for (int i = 0; i < opCodes.size(); i++) begin
         if (opCodes[i] == "E") begin
            runCipher(keys[i], blocks[i], 1'b0, res);
            check($sformatf("RESULT encrypt vector %0d", i), expectedOut[i], res);
            runCipher(keys[i], res, 1'b1, back);
            check($sformatf("RESULT round trip vector %0d", i), blocks[i], back);
         end else begin
            runCipher(keys[i], blocks[i], 1'b1, res);
            check($sformatf("RESULT decrypt vector %0d", i), expectedOut[i], res);
         end
      end

      firstEnc = -1;
      for (int i = 0; i < opCodes.size(); i++) begin
         if (opCodes[i] == "E" && firstEnc < 0) firstEnc = i;
      end
      if (firstEnc < 0) begin
         $display("ERROR: no encryption vector is available for the busy test");
         errors++;
      end else begin
         busyStartCheck(keys[firstEnc], blocks[firstEnc], expectedOut[firstEnc]);
      end

      // Rejected writes. 0x1E is not a register offset.
      axiWrite(`REG_STATUS, 32'h0000_0003, resp);
      check("bresp STATUS write", 64'(`AXI_RESP_SLVERR), 64'(resp));
      axiWrite(`REG_RESULT_LO, 32'hFFFF_FFFF, resp);
      check("bresp RESULT_LO write", 64'(`AXI_RESP_SLVERR), 64'(resp));
      axiWrite(5'h1E, 32'h1234_5678, resp);
      check("bresp unmapped write", 64'(`AXI_RESP_SLVERR), 64'(resp));
      axiRead(5'h1E, word, resp);
      check("rresp unmapped read", 64'(`AXI_RESP_SLVERR), 64'(resp));
      readReg(`REG_STATUS, word);
      check("STATUS", 64'(32'h2), 64'(word));
      readResult(res);
      check("RESULT after rejected writes", lastResult, res);
      readReg(`REG_KEY_HI, word);
      check("KEY_HI", 64'(lastKey[63:32]), 64'(word));
      readReg(`REG_KEY_LO, word);
      check("KEY_LO", 64'(lastKey[31:0]), 64'(word));
      readReg(`REG_DATA_HI, word);
      check("DATA_HI", 64'(lastData[63:32]), 64'(word));
      readReg(`REG_DATA_LO, word);
      check("DATA_LO", 64'(lastData[31:0]), 64'(word));

      $display("Summary: %0d errors in %0d checks", errors, checks);
      if (errors == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

/* source/desTop.sv */
module desTop (
   input  logic               clk,
   input  logic               rst,
   input  desPkg::axiLiteReq  axiReq,
   output desPkg::axiLiteResp axiResp
);
   import desPkg::*;

   logic       start;
   logic       busy;
   logic       done;
   desCoreReq  coreReq;
   desCoreResp coreResp;

   desAxiRegs desAxiRegs_i (
      .clk    (clk),
      .rst    (rst),
      .axiReq (axiReq),
      .axiResp(axiResp),
      .start  (start),
      .coreReq(coreReq),
      .busy   (busy),
      .done   (done),
      .result (coreResp)
   );

   // Iterative core, one round per clock.
   desCore desCore_i (
      .clk  (clk),
      .rst  (rst),
      .start(start),
      .req  (coreReq),
      .busy (busy),
      .done (done),
      .resp (coreResp)
   );

endmodule

/* source/desAxiRegs.sv */
`include "des_macros.svh"

module desAxiRegs (
   input  logic               clk,
   input  logic               rst,
   input  desPkg::axiLiteReq  axiReq,
   output desPkg::axiLiteResp axiResp,
   output logic               start,
   output desPkg::desCoreReq  coreReq,
   input  logic               busy,
   input  logic               done,
   input  desPkg::desCoreResp result
);
   import desPkg::*;

   axiData     keyHi;
   axiData     keyLo;
   axiData     dataHi;
   axiData     dataLo;
   logic       decryptBit;
   logic       doneBit;
   desBlock    resultReg;
   logic       coreBusy;

   logic       wrReady;
   logic       wrFire;
   logic       wrErr;
   logic       bValid;
   logic [1:0] bResp;

   logic       arReady;
   logic       rdFire;
   logic       rdErr;
   axiData     rdWord;
   logic       rValid;
   axiData     rData;
   logic [1:0] rResp;

   assign coreBusy = busy || start;  // Pending start counts as busy.
   assign wrFire   = wrReady && axiReq.awvalid && axiReq.wvalid;
   assign rdFire   = arReady && axiReq.arvalid;

   always_comb begin
      wrErr = 1'b0;
      case (axiReq.awaddr)
         `REG_KEY_HI, `REG_KEY_LO, `REG_DATA_HI, `REG_DATA_LO: wrErr = 1'b0;
         `REG_CTRL: wrErr = axiReq.wdata[`CTRL_START] && coreBusy;
         default:   wrErr = 1'b1;  // Read-only or unmapped.
      endcase
   end

   // ********************
   always_ff @(posedge clk) begin
      if (rst) begin
         keyHi      <= '0;
         keyLo      <= '0;
         dataHi     <= '0;
         dataLo     <= '0;
         decryptBit <= 1'b0;
         doneBit    <= 1'b0;
         resultReg  <= '0;
         start      <= 1'b0;
         wrReady    <= 1'b0;
         bValid     <= 1'b0;
         bResp      <= `AXI_RESP_OKAY;
      end else begin
         start   <= 1'b0;
         wrReady <= axiReq.awvalid && axiReq.wvalid && !wrReady && !bValid;
         if (done) begin
            doneBit   <= 1'b1;
            resultReg <= result.result;
         end
         if (wrFire) begin
            bValid <= 1'b1;
            bResp  <= wrErr ? `AXI_RESP_SLVERR : `AXI_RESP_OKAY;
            if (!wrErr) begin
               case (axiReq.awaddr)
                  `REG_KEY_HI:  keyHi  <= axiReq.wdata;
                  `REG_KEY_LO:  keyLo  <= axiReq.wdata;
                  `REG_DATA_HI: dataHi <= axiReq.wdata;
                  `REG_DATA_LO: dataLo <= axiReq.wdata;
                  `REG_CTRL: begin
                     decryptBit <= axiReq.wdata[`CTRL_DECRYPT];
                     if (axiReq.wdata[`CTRL_START]) begin
                        start   <= 1'b1;
                        doneBit <= 1'b0;
                     end
                  end
                  default: ;
               endcase
            end
         end else if (bValid && axiReq.bready) begin
            bValid <= 1'b0;
         end
      end
   end

   // ********************
   always_comb begin
      rdWord = '0;
      rdErr  = 1'b0;
      case (axiReq.araddr)
         `REG_KEY_HI:    rdWord = keyHi;
         `REG_KEY_LO:    rdWord = keyLo;
         `REG_DATA_HI:   rdWord = dataHi;
         `REG_DATA_LO:   rdWord = dataLo;
         `REG_CTRL:      rdWord[`CTRL_DECRYPT] = decryptBit;
         `REG_STATUS: begin
            rdWord[`STATUS_BUSY] = coreBusy;
            rdWord[`STATUS_DONE] = doneBit;
         end
         `REG_RESULT_HI: rdWord = resultReg[63:32];
         `REG_RESULT_LO: rdWord = resultReg[31:0];
         default:        rdErr  = 1'b1;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         arReady <= 1'b0;
         rValid  <= 1'b0;
         rData   <= '0;
         rResp   <= `AXI_RESP_OKAY;
      end else begin
         arReady <= axiReq.arvalid && !arReady && !rValid;
         if (rdFire) begin
            rValid <= 1'b1;
            rData  <= rdWord;  // Held until rready.
            rResp  <= rdErr ? `AXI_RESP_SLVERR : `AXI_RESP_OKAY;
         end else if (rValid && axiReq.rready) begin
            rValid <= 1'b0;
         end
      end
   end

   assign axiResp.awready = wrReady;
   assign axiResp.wready  = wrReady;
   assign axiResp.bresp   = bResp;
   assign axiResp.bvalid  = bValid;
   assign axiResp.arready = arReady;
   assign axiResp.rdata   = rData;
   assign axiResp.rresp   = rResp;
   assign axiResp.rvalid  = rValid;

   assign coreReq.data    = {dataHi, dataLo};
   assign coreReq.key     = {keyHi, keyLo};
   assign coreReq.decrypt = decryptBit;

endmodule

/* source/desCore.sv */
`include "des_macros.svh"

module desCore (
   input  logic               clk,
   input  logic               rst,
   input  logic               start,
   input  desPkg::desCoreReq  req,
   output logic               busy,
   output logic               done,
   output desPkg::desCoreResp resp
);
   import desPkg::*;

   localparam int IP_TABLE [64] = '{
      58, 50, 42, 34, 26, 18, 10,  2,
      60, 52, 44, 36, 28, 20, 12,  4,
      62, 54, 46, 38, 30, 22, 14,  6,
      64, 56, 48, 40, 32, 24, 16,  8,
      57, 49, 41, 33, 25, 17,  9,  1,
      59, 51, 43, 35, 27, 19, 11,  3,
      61, 53, 45, 37, 29, 21, 13,  5,
      63, 55, 47, 39, 31, 23, 15,  7
   };

   coreState   state;
   logic [3:0] roundCnt;
   desHalf     l;
   desHalf     r;
   desHalf     f;
   logic       decryptQ;
   logic       load;
   logic       keyDecrypt;
   keyHalf     c0;
   keyHalf     d0;
   subKey      roundKey;
   desBlock    ipOut;
   desBlock    preOut;
   desBlock    fpOut;

   assign load       = (state == IDLE) && start;
   assign keyDecrypt = load ? req.decrypt : decryptQ;
   assign busy       = (state == ROUND);
   assign done       = (state == FINISH);
   assign preOut     = {l ^ f, r};  // Round 16 output, halves swapped.

   always_comb begin
      for (int i = 0; i < 64; i++) begin
         ipOut[6'(63 - i)] = req.data[6'(64 - IP_TABLE[i])];
         fpOut[6'(64 - IP_TABLE[i])] = preOut[6'(63 - i)];  // Inverse of IP.
      end
   end

   keyPermChoice1 keyPermChoice1_i (
      .key(req.key),
      .c  (c0),
      .d  (d0)
   );

   roundKeyGen roundKeyGen_i (
      .clk    (clk),
      .rst    (rst),
      .load   (load),
      .cIn    (c0),
      .dIn    (d0),
      .decrypt(keyDecrypt),
      .advance(busy),
      .round  (roundCnt),
      .key    (roundKey)
   );

   desRound desRound_i (
      .r  (r),
      .key(roundKey),
      .f  (f)
   );

   // ********************
   always_ff @(posedge clk) begin
      if (rst) begin
         state    <= IDLE;
         roundCnt <= '0;
         resp     <= '0;
      end else begin
         case (state)
            IDLE: begin
               if (start) begin
                  state    <= ROUND;
                  roundCnt <= '0;
               end
            end
            ROUND: begin
               roundCnt <= roundCnt + 4'd1;
               if (roundCnt == 4'(`DES_ROUNDS - 1)) begin
                  state       <= FINISH;
                  resp.result <= fpOut;
               end
            end
            default: state <= IDLE;  // FINISH lasts one cycle.
         endcase
      end
   end

   // Feistel halves.
   always_ff @(posedge clk) begin
      if (load) begin
         {l, r}   <= ipOut;
         decryptQ <= req.decrypt;
      end else if (busy) begin
         l <= r;
         r <= l ^ f;
      end
   end

endmodule

/* source/desRound.sv */
module desRound (
   input  desPkg::desHalf r,
   input  desPkg::subKey  key,
   output desPkg::desHalf f
);
   import desPkg::*;

   localparam int E_TABLE [48] = '{
      32,  1,  2,  3,  4,  5,
       4,  5,  6,  7,  8,  9,
       8,  9, 10, 11, 12, 13,
      12, 13, 14, 15, 16, 17,
      16, 17, 18, 19, 20, 21,
      20, 21, 22, 23, 24, 25,
      24, 25, 26, 27, 28, 29,
      28, 29, 30, 31, 32,  1
   };

   localparam int P_TABLE [32] = '{
      16,  7, 20, 21, 29, 12, 28, 17,
       1, 15, 23, 26,  5, 18, 31, 10,
       2,  8, 24, 14, 32, 27,  3,  9,
      19, 13, 30,  6, 22, 11,  4, 25
   };

   // ********************
   // Rows of 16, row picked by the outer input bits.
   localparam int SBOX [8][64] = '{
      '{14, 4, 13, 1, 2, 15, 11, 8, 3, 10, 6, 12, 5, 9, 0, 7,
        0, 15, 7, 4, 14, 2, 13, 1, 10, 6, 12, 11, 9, 5, 3, 8,
        4, 1, 14, 8, 13, 6, 2, 11, 15, 12, 9, 7, 3, 10, 5, 0,
        15, 12, 8, 2, 4, 9, 1, 7, 5, 11, 3, 14, 10, 0, 6, 13},
      '{15, 1, 8, 14, 6, 11, 3, 4, 9, 7, 2, 13, 12, 0, 5, 10,
        3, 13, 4, 7, 15, 2, 8, 14, 12, 0, 1, 10, 6, 9, 11, 5,
        0, 14, 7, 11, 10, 4, 13, 1, 5, 8, 12, 6, 9, 3, 2, 15,
        13, 8, 10, 1, 3, 15, 4, 2, 11, 6, 7, 12, 0, 5, 14, 9},
      '{10, 0, 9, 14, 6, 3, 15, 5, 1, 13, 12, 7, 11, 4, 2, 8,
        13, 7, 0, 9, 3, 4, 6, 10, 2, 8, 5, 14, 12, 11, 15, 1,
        13, 6, 4, 9, 8, 15, 3, 0, 11, 1, 2, 12, 5, 10, 14, 7,
        1, 10, 13, 0, 6, 9, 8, 7, 4, 15, 14, 3, 11, 5, 2, 12},
      '{7, 13, 14, 3, 0, 6, 9, 10, 1, 2, 8, 5, 11, 12, 4, 15,
        13, 8, 11, 5, 6, 15, 0, 3, 4, 7, 2, 12, 1, 10, 14, 9,
        10, 6, 9, 0, 12, 11, 7, 13, 15, 1, 3, 14, 5, 2, 8, 4,
        3, 15, 0, 6, 10, 1, 13, 8, 9, 4, 5, 11, 12, 7, 2, 14},
      '{2, 12, 4, 1, 7, 10, 11, 6, 8, 5, 3, 15, 13, 0, 14, 9,
        14, 11, 2, 12, 4, 7, 13, 1, 5, 0, 15, 10, 3, 9, 8, 6,
        4, 2, 1, 11, 10, 13, 7, 8, 15, 9, 12, 5, 6, 3, 0, 14,
        11, 8, 12, 7, 1, 14, 2, 13, 6, 15, 0, 9, 10, 4, 5, 3},
      '{12, 1, 10, 15, 9, 2, 6, 8, 0, 13, 3, 4, 14, 7, 5, 11,
        10, 15, 4, 2, 7, 12, 9, 5, 6, 1, 13, 14, 0, 11, 3, 8,
        9, 14, 15, 5, 2, 8, 12, 3, 7, 0, 4, 10, 1, 13, 11, 6,
        4, 3, 2, 12, 9, 5, 15, 10, 11, 14, 1, 7, 6, 0, 8, 13},
      '{4, 11, 2, 14, 15, 0, 8, 13, 3, 12, 9, 7, 5, 10, 6, 1,
        13, 0, 11, 7, 4, 9, 1, 10, 14, 3, 5, 12, 2, 15, 8, 6,
        1, 4, 11, 13, 12, 3, 7, 14, 10, 15, 6, 8, 0, 5, 9, 2,
        6, 11, 13, 8, 1, 4, 10, 7, 9, 5, 0, 15, 14, 2, 3, 12},
      '{13, 2, 8, 4, 6, 15, 11, 1, 10, 9, 3, 14, 5, 0, 12, 7,
        1, 15, 13, 8, 10, 3, 7, 4, 12, 5, 6, 11, 0, 14, 9, 2,
        7, 11, 4, 1, 9, 12, 14, 2, 0, 6, 10, 13, 15, 3, 5, 8,
        2, 1, 14, 7, 4, 10, 8, 13, 15, 12, 9, 0, 3, 5, 6, 11}
   };

   subKey       expanded;
   subKey       mixed;
   logic [31:0] sOut;

   always_comb begin
      for (int i = 0; i < 48; i++) begin
         expanded[6'(47 - i)] = r[5'(32 - E_TABLE[i])];
      end
   end

   assign mixed = expanded ^ key;

   always_comb begin
      logic [5:0] chunk;
      for (int i = 0; i < 8; i++) begin
         chunk = mixed[6'(47 - 6 * i) -: 6];  // S1 takes the top six bits.
         sOut[5'(31 - 4 * i) -: 4] = 4'(SBOX[3'(i)][{chunk[5], chunk[0], chunk[4:1]}]);
      end
   end

   always_comb begin
      for (int i = 0; i < 32; i++) begin
         f[5'(31 - i)] = sOut[5'(32 - P_TABLE[i])];
      end
   end

endmodule

/* keySchedule/roundKeyGen.sv */
module roundKeyGen (
   input  logic           clk,
   input  logic           rst,
   input  logic           load,
   input  desPkg::keyHalf cIn,
   input  desPkg::keyHalf dIn,
   input  logic           decrypt,
   input  logic           advance,
   input  logic [3:0]     round,
   output desPkg::subKey  key
);
   import desPkg::*;

   // Bit n set when round n+1 shifts by two.
   localparam logic [15:0] SHIFT_TWO = 16'b0111_1110_1111_1100;

   localparam int PC2_TABLE [48] = '{
      14, 17, 11, 24,  1,  5,
       3, 28, 15,  6, 21, 10,
      23, 19, 12,  4, 26,  8,
      16,  7, 27, 20, 13,  2,
      41, 52, 31, 37, 47, 55,
      30, 40, 51, 45, 33, 48,
      44, 49, 39, 56, 34, 53,
      46, 42, 50, 36, 29, 32
   };

   keyHalf      c;
   keyHalf      d;
   logic [55:0] cd;
   logic [3:0]  encIdx;
   logic [3:0]  decIdx;

   function automatic keyHalf rotLeft(keyHalf x, logic two);
      return two ? {x[25:0], x[27:26]} : {x[26:0], x[27]};
   endfunction

   function automatic keyHalf rotRight(keyHalf x, logic two);
      return two ? {x[1:0], x[27:2]} : {x[0], x[27:1]};
   endfunction

   assign encIdx = round + 4'd1;   // Shift of the next round.
   assign decIdx = 4'd15 - round;  // Undo the key in use.
   assign cd     = {c, d};

   always_ff @(posedge clk) begin
      if (rst) begin
         c <= '0;
         d <= '0;
      end else if (load) begin
         // Round 1 key. Decryption starts from C16 which equals C0.
         c <= decrypt ? cIn : rotLeft(cIn, 1'b0);
         d <= decrypt ? dIn : rotLeft(dIn, 1'b0);
      end else if (advance) begin
         if (decrypt) begin
            c <= rotRight(c, SHIFT_TWO[decIdx]);
            d <= rotRight(d, SHIFT_TWO[decIdx]);
         end else begin
            c <= rotLeft(c, SHIFT_TWO[encIdx]);
            d <= rotLeft(d, SHIFT_TWO[encIdx]);
         end
      end
   end

   always_comb begin
      for (int i = 0; i < 48; i++) begin
         key[6'(47 - i)] = cd[6'(56 - PC2_TABLE[i])];
      end
   end

endmodule

/* keySchedule/keyPermChoice1.sv */
module keyPermChoice1 (
   input  desPkg::desBlock key,
   output desPkg::keyHalf  c,
   output desPkg::keyHalf  d
);

   // Standard numbering, bit 1 is the key MSB.
   localparam int PC1_TABLE [56] = '{
      57, 49, 41, 33, 25, 17,  9,
       1, 58, 50, 42, 34, 26, 18,
      10,  2, 59, 51, 43, 35, 27,
      19, 11,  3, 60, 52, 44, 36,
      63, 55, 47, 39, 31, 23, 15,
       7, 62, 54, 46, 38, 30, 22,
      14,  6, 61, 53, 45, 37, 29,
      21, 13,  5, 28, 20, 12,  4
   };

   logic [55:0] selected;

   // Parity bits 8, 16 .. 64 never appear in the table.
   always_comb begin
      for (int i = 0; i < 56; i++) begin
         selected[6'(55 - i)] = key[6'(64 - PC1_TABLE[i])];
      end
   end

   assign c = selected[55:28];  // First 28 selected bits.
   assign d = selected[27:0];

endmodule

/* common/desPkg.sv */
`include "des_macros.svh"

package desPkg;

   typedef logic [63:0] desBlock;
   typedef logic [31:0] desHalf;
   typedef logic [27:0] keyHalf;
   typedef logic [47:0] subKey;
   typedef logic [`DES_ADDR_WIDTH-1:0] axiAddr;
   typedef logic [31:0] axiData;

   typedef struct packed {
      desBlock data;
      desBlock key;
      logic    decrypt;
   } desCoreReq;

   typedef struct packed {
      desBlock result;
   } desCoreResp;

   // ********************
   typedef struct packed {
      axiAddr awaddr;
      logic   awvalid;
      axiData wdata;
      logic   wvalid;
      logic   bready;
      axiAddr araddr;
      logic   arvalid;
      logic   rready;
   } axiLiteReq;

   typedef struct packed {
      logic       awready;
      logic       wready;
      logic [1:0] bresp;
      logic       bvalid;
      logic       arready;
      axiData     rdata;
      logic [1:0] rresp;
      logic       rvalid;
   } axiLiteResp;

   typedef enum logic [1:0] {
      IDLE,
      ROUND,
      FINISH
   } coreState;

endpackage

/* common/des_macros.svh */
`ifndef DES_MACROS_SVH
`define DES_MACROS_SVH

`define DES_ADDR_WIDTH  5
`define DES_ROUNDS      16

// Register byte offsets.
`define REG_KEY_HI      5'h00
`define REG_KEY_LO      5'h04
`define REG_DATA_HI     5'h08
`define REG_DATA_LO     5'h0C
`define REG_CTRL        5'h10
`define REG_STATUS      5'h14
`define REG_RESULT_HI   5'h18
`define REG_RESULT_LO   5'h1C

`define CTRL_START      0
`define CTRL_DECRYPT    1
`define STATUS_BUSY     0
`define STATUS_DONE     1

`define AXI_RESP_OKAY   2'b00
`define AXI_RESP_SLVERR 2'b10

`endif
